// ==== boxhead_core.f ====
+incdir+include
src/boxhead_pkg.sv
src/frame_gate.sv
src/player_unit.sv
src/enemy_pack.sv
src/combat_logic.sv
src/status_display.sv
src/boxhead_core.sv
verif/boxhead_chk.sv
verif/boxhead_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the game core testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module boxhead_tb -f boxhead_core.f -o boxhead_sim || exit 1

out="$(./obj_dir/boxhead_sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "test passed" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/boxhead_tb.sv ====
//--------------------------------------------------------------------------
// Testbench for the arena game core
// LFSR key stimulus, reference game model and per-frame compare
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "boxhead_config.svh"

module boxhead_tb;
    import boxhead_pkg::*;

    localparam int N           = `BH_ENEMY_NUM;
    localparam int MAX_X       = `BH_FIELD_W - 1;
    localparam int MAX_Y       = `BH_FIELD_H - 1;
    localparam int FULL        = `BH_FULL_BLOOD;
    localparam int PRE_FRAMES  = 6;     // Frames before Enter
    localparam int MAX_FRAMES  = 600;
    localparam int POST_FRAMES = 20;
    localparam int CYCLE_LIMIT = 12 * (PRE_FRAMES + 1 + MAX_FRAMES) + 200;

    localparam int SPAWN_X [4] = '{`BH_SPAWN_X0, `BH_SPAWN_X1, `BH_SPAWN_X2, `BH_SPAWN_X3};
    localparam int SPAWN_Y [4] = '{`BH_SPAWN_Y0, `BH_SPAWN_Y1, `BH_SPAWN_Y2, `BH_SPAWN_Y3};

    // Lit segments gfedcba, active high
    localparam logic [6:0] SEG_LIT [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic       Clk;
    logic       arst_n;
    logic       frame_sync;
    logic [7:0] keycode;
    logic       running;
    pos_t       player;
    logic [7:0] score;
    logic [7:0] blood;
    logic       game_over;
    logic [6:0] hex [4];

    logic [15:0] lfsr = 16'd42758;
    int          cycles = 0;

    //----------------------------------------------------------------------
    // Reference game state
    //----------------------------------------------------------------------
    bit   started;
    int   px;
    int   py;
    dir_t facing;
    bit   atk_on;
    int   atk_x;
    int   atk_y;
    int   atk_cnt;
    bit   alive [N];
    int   ex [N];
    int   ey [N];
    int   resp [N];
    int   cool [N];
    int   score_ref;
    int   damage;

    boxhead_core boxhead_core_i (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .frame_sync (frame_sync),
        .keycode    (keycode),
        .running    (running),
        .player     (player),
        .score      (score),
        .blood      (blood),
        .game_over  (game_over),
        .hex        (hex)
    );

    bind boxhead_core boxhead_chk boxhead_chk_i (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .game_tick (game_tick),
        .game_over (game_over),
        .player    (player),
        .score     (score),
        .blood     (blood)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("TIMEOUT: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] random_key();
        logic [2:0] pick;
        for (int b = 0; b < 3; b++) begin
            lfsr    = lfsr_step(lfsr);
            pick[b] = lfsr[0];
        end
        case (pick)
            3'd0:    return KEY_W;
            3'd1:    return KEY_A;
            3'd2:    return KEY_S;
            3'd3:    return KEY_D;
            3'd4:    return KEY_SPACE;
            default: return 8'h00;  // No key
        endcase
    endfunction

    function automatic int clamp(input int v, input int hi);
        if (v < 0)
            return 0;
        return (v > hi) ? hi : v;
    endfunction

    function automatic int abs_diff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic int toward(input int c, input int t);
        if (c < t)
            return c + 1;
        if (c > t)
            return c - 1;
        return c;
    endfunction

    function automatic logic [6:0] seg_code(input logic [3:0] nib);
        return ~SEG_LIT[nib];
    endfunction

    function automatic void reset_model();
        started   = 1'b0;
        px        = `BH_FIELD_W / 2;
        py        = `BH_FIELD_H / 2;
        facing    = DIR_DOWN;
        atk_on    = 1'b0;
        atk_cnt   = 0;
        score_ref = 0;
        damage    = 0;
        for (int i = 0; i < N; i++) begin
            alive[i] = 1'b1;
            ex[i]    = SPAWN_X[i];
            ey[i]    = SPAWN_Y[i];
            resp[i]  = 0;
            cool[i]  = 0;
        end
    endfunction

    // One frame of the game; all decisions use the state from before the tick
    function automatic void step_game(input logic [7:0] key);
        bit hit;
        bit touch;
        if (key == KEY_ENTER)
            started = 1'b1;
        if (!started || damage > FULL)
            return;     // No tick
        for (int i = 0; i < N; i++) begin
            hit   = atk_on && alive[i] && abs_diff(ex[i], atk_x) <= `BH_HIT_RANGE &&
                    abs_diff(ey[i], atk_y) <= `BH_HIT_RANGE;
            touch = alive[i] && !hit && cool[i] == 0 &&
                    abs_diff(ex[i], px) <= `BH_TOUCH_RANGE &&
                    abs_diff(ey[i], py) <= `BH_TOUCH_RANGE;
            if (hit && score_ref < 255)
                score_ref++;
            if (touch) begin
                damage += `BH_ENEMY_DAMAGE;
                cool[i] = `BH_STRIKE_COOLDOWN;
            end else if (cool[i] > 0) begin
                cool[i]--;
            end
            if (hit) begin
                alive[i] = 1'b0;
                resp[i]  = `BH_RESPAWN_TICKS;
            end else if (!alive[i]) begin
                resp[i]--;
                if (resp[i] == 0) begin
                    alive[i] = 1'b1;
                    ex[i]    = SPAWN_X[i];
                    ey[i]    = SPAWN_Y[i];
                end
            end else begin
                ex[i] = toward(ex[i], px);
                ey[i] = toward(ey[i], py);
            end
        end
        if (atk_on) begin
            atk_cnt--;
            if (atk_cnt == 0)
                atk_on = 1'b0;
        end else if (key == KEY_SPACE) begin
            atk_on  = 1'b1;
            atk_cnt = `BH_ATTACK_TICKS;
            atk_x   = px;
            atk_y   = py;
            case (facing)
                DIR_UP:   atk_y = clamp(py - `BH_ATTACK_REACH, MAX_Y);
                DIR_DOWN: atk_y = clamp(py + `BH_ATTACK_REACH, MAX_Y);
                DIR_LEFT: atk_x = clamp(px - `BH_ATTACK_REACH, MAX_X);
                default:  atk_x = clamp(px + `BH_ATTACK_REACH, MAX_X);
            endcase
        end
        case (key)
            KEY_W: begin
                py     = clamp(py - 1, MAX_Y);
                facing = DIR_UP;
            end
            KEY_S: begin
                py     = clamp(py + 1, MAX_Y);
                facing = DIR_DOWN;
            end
            KEY_A: begin
                px     = clamp(px - 1, MAX_X);
                facing = DIR_LEFT;
            end
            KEY_D: begin
                px     = clamp(px + 1, MAX_X);
                facing = DIR_RIGHT;
            end
            default: ;
        endcase
    endfunction

    task automatic compare_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_outputs();
        attack_t atk;
        int      blood_exp;
        bit      over;
        atk       = boxhead_core_i.attack;
        over      = damage > FULL;
        blood_exp = (damage >= FULL) ? 0 : FULL - damage;
        compare_value("running", running, started && !over);
        compare_value("player.x", player.x, px);
        compare_value("player.y", player.y, py);
        compare_value("score", score, score_ref);
        compare_value("blood", blood, blood_exp);
        compare_value("game_over", game_over, over);
        compare_value("attack.on", atk.on, atk_on);
        if (atk_on) begin
            compare_value("attack.x", atk.pos.x, atk_x);
            compare_value("attack.y", atk.pos.y, atk_y);
        end
        compare_value("hex[0]", hex[0], seg_code(score_ref[3:0]));
        compare_value("hex[1]", hex[1], seg_code(score_ref[7:4]));
        compare_value("hex[2]", hex[2], seg_code(blood_exp[3:0]));
        compare_value("hex[3]", hex[3], seg_code(blood_exp[7:4]));
    endtask

    // One 12-cycle frame with vsync high for 6, starting on a rising edge
    task automatic run_frame(input logic [7:0] key);
        keycode    <= key;
        frame_sync <= 1'b1;
        step_game(key);
        repeat (6) @(posedge Clk);
        frame_sync <= 1'b0;
        repeat (6) @(posedge Clk);
    endtask

    // Outputs settle 3 cycles after the vsync rise
    initial begin : compare
        forever begin
            @(posedge frame_sync);
            repeat (4) @(posedge Clk);
            @(negedge Clk);
            compare_outputs();
        end
    end

    initial begin : stimulus
        int frames;
        int post;
        arst_n     = 1'b0;
        frame_sync = 1'b0;
        keycode    = 8'h00;
        frames     = 0;
        post       = 0;
        reset_model();
        repeat (5) @(posedge Clk);
        arst_n <= 1'b1;
        repeat (3) @(posedge Clk);

        for (int f = 0; f < PRE_FRAMES; f++)
            run_frame(random_key());    // Ignored until Enter
        run_frame(KEY_ENTER);

        while (frames < MAX_FRAMES && post <= POST_FRAMES) begin
            run_frame(random_key());
            if (damage > FULL)
                post++;
            frames++;
        end

        if (post <= POST_FRAMES) begin
            $display("Game over was not reached and held within %0d frames", MAX_FRAMES);
            $display("test failed");
            $fatal(1, "game over missing");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verif/boxhead_chk.sv ====
//--------------------------------------------------------------------------
// Concurrent assertions on the game invariants of the core
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module boxhead_chk (
    input  logic              Clk,
    input  logic              arst_n,
    input  logic              game_tick,
    input  logic              game_over,
    input  boxhead_pkg::pos_t player,
    input  logic [7:0]        score,
    input  logic [7:0]        blood
);

    a_over_sticky: assert property (@(posedge Clk) disable iff (!arst_n)
        game_over |=> game_over) else $error("game over was cleared");

    // Combat raises game over as the gate registers its next tick
    a_over_no_tick: assert property (@(posedge Clk) disable iff (!arst_n)
        game_over |-> !game_tick) else $error("tick after game over");

    a_over_frozen: assert property (@(posedge Clk) disable iff (!arst_n)
        game_over |=> $stable(player) && $stable(score) && $stable(blood))
        else $error("game state moved after game over");

endmodule

`default_nettype wire

// ==== src/boxhead_core.sv ====
//--------------------------------------------------------------------------
// Game-state core top level
// Tick gate, player and enemy units, combat and status digits
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "boxhead_config.svh"

module boxhead_core (
    input  logic              Clk,
    input  logic              arst_n,
    input  logic              frame_sync,
    input  logic [7:0]        keycode,
    output logic              running,
    output boxhead_pkg::pos_t player,
    output logic [7:0]        score,
    output logic [7:0]        blood,
    output logic              game_over,
    output logic [6:0]        hex [4]
);
    import boxhead_pkg::*;

    logic                     game_tick;
    attack_t                  attack;
    enemy_t                   enemies [`BH_ENEMY_NUM];
    logic [`BH_ENEMY_NUM-1:0] strike;
    logic [`BH_ENEMY_NUM-1:0] kill;

    frame_gate frame_gate_i (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .frame_sync (frame_sync),
        .keycode    (keycode),
        .game_over  (game_over),
        .game_tick  (game_tick),
        .running    (running)
    );

    // Player and enemies update side by side on the tick
    player_unit player_unit_i (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .game_tick (game_tick),
        .keycode   (keycode),
        .player    (player),
        .attack    (attack)
    );

    enemy_pack enemy_pack_i (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .game_tick (game_tick),
        .player    (player),
        .kill      (kill),
        .enemies   (enemies),
        .strike    (strike)
    );

    combat_logic combat_logic_i (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .game_tick (game_tick),
        .attack    (attack),
        .enemies   (enemies),
        .strike    (strike),
        .kill      (kill),
        .score     (score),
        .blood     (blood),
        .game_over (game_over)
    );

    status_display status_display_i (
        .score (score),
        .blood (blood),
        .hex   (hex)
    );

endmodule

`default_nettype wire

// ==== src/status_display.sv ====
//--------------------------------------------------------------------------
// Seven-segment decode of score and blood, active low
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module status_display (
    input  logic [7:0] score,
    input  logic [7:0] blood,
    output logic [6:0] hex [4]
);

    // Segment order gfedcba
    function automatic logic [6:0] seg7(input logic [3:0] nib);
        case (nib)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'hA:    return 7'b0001000;
            4'hB:    return 7'b0000011;
            4'hC:    return 7'b1000110;
            4'hD:    return 7'b0100001;
            4'hE:    return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    assign hex[0] = seg7(score[3:0]);
    assign hex[1] = seg7(score[7:4]);
    assign hex[2] = seg7(blood[3:0]);
    assign hex[3] = seg7(blood[7:4]);

endmodule

`default_nettype wire

// ==== src/combat_logic.sv ====
//--------------------------------------------------------------------------
// Attack hit tests, score and damage bookkeeping
// Blood and game over follow the damage total
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "boxhead_config.svh"

module combat_logic (
    input  logic                      Clk,
    input  logic                      arst_n,
    input  logic                      game_tick,
    input  boxhead_pkg::attack_t      attack,
    input  boxhead_pkg::enemy_t       enemies [`BH_ENEMY_NUM],
    input  logic [`BH_ENEMY_NUM-1:0]  strike,
    output logic [`BH_ENEMY_NUM-1:0]  kill,
    output logic [7:0]                score,
    output logic [7:0]                blood,
    output logic                      game_over
);
    import boxhead_pkg::*;

    localparam int     CNT_W = $clog2(`BH_ENEMY_NUM + 1);
    localparam int     DMG_W = 10;
    localparam coord_t HIT   = coord_t'(`BH_HIT_RANGE);
    localparam logic [DMG_W-1:0] FULL = DMG_W'(`BH_FULL_BLOOD);

    logic [CNT_W-1:0] kill_num;
    logic [CNT_W-1:0] strike_num;
    logic [8:0]       score_sum;
    logic [DMG_W-1:0] damage_total;
    logic [DMG_W-1:0] blood_left;

    //----------------------------------------------------------------------
    // Hit test against the pre-tick positions
    //----------------------------------------------------------------------
    always_comb begin
        kill_num   = '0;
        strike_num = '0;
        for (int i = 0; i < `BH_ENEMY_NUM; i++) begin
            kill[i] = game_tick & attack.on & enemies[i].alive &
                      (coord_dist(enemies[i].pos.x, attack.pos.x) <= HIT) &
                      (coord_dist(enemies[i].pos.y, attack.pos.y) <= HIT);
            kill_num   = kill_num + CNT_W'(kill[i]);
            strike_num = strike_num + CNT_W'(strike[i]);
        end
    end

    assign score_sum = {1'b0, score} + 9'(kill_num);

    //----------------------------------------------------------------------
    // Score and damage registers
    //----------------------------------------------------------------------
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            score        <= '0;
            damage_total <= '0;
        end else if (game_tick) begin
            score        <= score_sum[8] ? 8'hFF : score_sum[7:0];  // Saturates
            damage_total <= damage_total + DMG_W'(strike_num * `BH_ENEMY_DAMAGE);
        end
    end

    // Ticks stop at game over so the total cannot wrap
    assign blood_left = FULL - damage_total;
    assign blood      = (damage_total >= FULL) ? 8'd0 : blood_left[7:0];
    assign game_over  = damage_total > FULL;

endmodule

`default_nettype wire

// ==== src/enemy_pack.sv ====
//--------------------------------------------------------------------------
// Four chasing enemies with respawn timers and strike cooldowns
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "boxhead_config.svh"

module enemy_pack (
    input  logic                      Clk,
    input  logic                      arst_n,
    input  logic                      game_tick,
    input  boxhead_pkg::pos_t         player,
    input  logic [`BH_ENEMY_NUM-1:0]  kill,
    output boxhead_pkg::enemy_t       enemies [`BH_ENEMY_NUM],
    output logic [`BH_ENEMY_NUM-1:0]  strike
);
    import boxhead_pkg::*;

    localparam int     RESP_W = $clog2(`BH_RESPAWN_TICKS + 1);
    localparam int     COOL_W = $clog2(`BH_STRIKE_COOLDOWN + 1);
    localparam coord_t TOUCH  = coord_t'(`BH_TOUCH_RANGE);

    localparam coord_t SPAWN_X [4] = '{coord_t'(`BH_SPAWN_X0), coord_t'(`BH_SPAWN_X1),
                                      coord_t'(`BH_SPAWN_X2), coord_t'(`BH_SPAWN_X3)};
    localparam coord_t SPAWN_Y [4] = '{coord_t'(`BH_SPAWN_Y0), coord_t'(`BH_SPAWN_Y1),
                                      coord_t'(`BH_SPAWN_Y2), coord_t'(`BH_SPAWN_Y3)};

    // One pixel toward the target
    function automatic coord_t step_toward(input coord_t c, input coord_t target);
        if (c < target)
            return c + 1'b1;
        else if (c > target)
            return c - 1'b1;
        return c;
    endfunction

    for (genvar i = 0; i < `BH_ENEMY_NUM; i++) begin : g_enemy
        localparam pos_t SPAWN = '{x: SPAWN_X[i], y: SPAWN_Y[i]};

        enemy_t            state;
        logic [RESP_W-1:0] respawn_cnt;
        logic [COOL_W-1:0] cooldown;
        logic              near;

        assign near = (coord_dist(state.pos.x, player.x) <= TOUCH) &&
                      (coord_dist(state.pos.y, player.y) <= TOUCH);
        assign strike[i]  = game_tick & state.alive & near & (cooldown == '0) & ~kill[i];
        assign enemies[i] = state;

        always_ff @(posedge Clk or negedge arst_n) begin
            if (!arst_n) begin
                state       <= '{alive: 1'b1, pos: SPAWN};
                respawn_cnt <= '0;
                cooldown    <= '0;
            end else if (game_tick) begin
                if (strike[i])
                    cooldown <= COOL_W'(`BH_STRIKE_COOLDOWN);
                else if (cooldown != '0)
                    cooldown <= cooldown - 1'b1;

                if (kill[i]) begin
                    state.alive <= 1'b0;
                    respawn_cnt <= RESP_W'(`BH_RESPAWN_TICKS);
                end else if (!state.alive) begin
                    if (respawn_cnt == RESP_W'(1)) begin
                        state       <= '{alive: 1'b1, pos: SPAWN};  // Back at its corner
                        respawn_cnt <= '0;
                    end else begin
                        respawn_cnt <= respawn_cnt - 1'b1;
                    end
                end else begin
                    state.pos.x <= step_toward(state.pos.x, player.x);
                    state.pos.y <= step_toward(state.pos.y, player.y);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/player_unit.sv ====
//--------------------------------------------------------------------------
// Player movement and facing
// Timed sword attack point in front of the player
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "boxhead_config.svh"

module player_unit (
    input  logic                 Clk,
    input  logic                 arst_n,
    input  logic                 game_tick,
    input  logic [7:0]           keycode,
    output boxhead_pkg::pos_t    player,
    output boxhead_pkg::attack_t attack
);
    import boxhead_pkg::*;

    localparam int     ATK_CNT_W = $clog2(`BH_ATTACK_TICKS + 1);
    localparam coord_t MAX_X     = coord_t'(`BH_FIELD_W - 1);
    localparam coord_t MAX_Y     = coord_t'(`BH_FIELD_H - 1);
    localparam coord_t REACH     = coord_t'(`BH_ATTACK_REACH);

    dir_t                 facing;
    logic [ATK_CNT_W-1:0] atk_cnt;
    pos_t                 move_pos;
    dir_t                 move_dir;
    pos_t                 reach_pos;

    // c + d, clamped to lim
    function automatic coord_t add_clamp(input coord_t c, input coord_t d, input coord_t lim);
        logic [$bits(coord_t):0] sum;
        sum = {1'b0, c} + {1'b0, d};
        return (sum > {1'b0, lim}) ? lim : sum[$bits(coord_t)-1:0];
    endfunction

    // c - d, floored at 0
    function automatic coord_t sub_clamp(input coord_t c, input coord_t d);
        return (c >= d) ? c - d : '0;
    endfunction

    always_comb begin
        move_pos = player;
        move_dir = facing;
        case (keycode)
            KEY_W: begin
                move_pos.y = sub_clamp(player.y, coord_t'(1));
                move_dir   = DIR_UP;
            end
            KEY_S: begin
                move_pos.y = add_clamp(player.y, coord_t'(1), MAX_Y);
                move_dir   = DIR_DOWN;
            end
            KEY_A: begin
                move_pos.x = sub_clamp(player.x, coord_t'(1));
                move_dir   = DIR_LEFT;
            end
            KEY_D: begin
                move_pos.x = add_clamp(player.x, coord_t'(1), MAX_X);
                move_dir   = DIR_RIGHT;
            end
            default: ;
        endcase
    end

    // Attack point from the pre-tick position and facing
    always_comb begin
        reach_pos = player;
        case (facing)
            DIR_UP:   reach_pos.y = sub_clamp(player.y, REACH);
            DIR_DOWN: reach_pos.y = add_clamp(player.y, REACH, MAX_Y);
            DIR_LEFT: reach_pos.x = sub_clamp(player.x, REACH);
            default:  reach_pos.x = add_clamp(player.x, REACH, MAX_X);
        endcase
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            player   <= '{x: coord_t'(`BH_FIELD_W / 2), y: coord_t'(`BH_FIELD_H / 2)};
            facing   <= DIR_DOWN;
            attack   <= '0;
            atk_cnt  <= '0;
        end else if (game_tick) begin
            player <= move_pos;
            facing <= move_dir;
            if (attack.on) begin
                atk_cnt <= atk_cnt - 1'b1;
                if (atk_cnt == ATK_CNT_W'(1))
                    attack.on <= 1'b0;  // Last attack tick
            end else if (keycode == KEY_SPACE) begin
                attack  <= '{on: 1'b1, pos: reach_pos};
                atk_cnt <= ATK_CNT_W'(`BH_ATTACK_TICKS);
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/frame_gate.sv ====
//--------------------------------------------------------------------------
// Start latch and vertical sync edge detect
// Produces the one-cycle game tick while the game runs
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module frame_gate (
    input  logic       Clk,
    input  logic       arst_n,
    input  logic       frame_sync,
    input  logic [7:0] keycode,
    input  logic       game_over,
    output logic       game_tick,
    output logic       running
);
    import boxhead_pkg::*;

    logic sync_q;       // Synchronised vsync
    logic sync_d;
    logic sync_rise;
    logic started;

    assign sync_rise = sync_q & ~sync_d;
    assign running   = started & ~game_over;

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q    <= 1'b0;
            sync_d    <= 1'b0;
            started   <= 1'b0;
            game_tick <= 1'b0;
        end else begin
            sync_q <= frame_sync;
            sync_d <= sync_q;
            if (keycode == KEY_ENTER)
                started <= 1'b1;    // Held until reset
            game_tick <= sync_rise & running;   // Edges outside a game are dropped
        end
    end

endmodule

`default_nettype wire

// ==== src/boxhead_pkg.sv ====
//--------------------------------------------------------------------------
// Shared game types and keyboard scan codes
//--------------------------------------------------------------------------
`default_nettype none

`include "boxhead_config.svh"

package boxhead_pkg;

    typedef logic [`BH_COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    typedef enum logic [1:0] {
        DIR_UP,
        DIR_DOWN,
        DIR_LEFT,
        DIR_RIGHT
    } dir_t;

    typedef struct packed {
        logic on;
        pos_t pos;      // Fixed while the attack lasts
    } attack_t;

    typedef struct packed {
        logic alive;
        pos_t pos;
    } enemy_t;

    // USB HID scan codes
    localparam logic [7:0] KEY_W     = 8'h1A;
    localparam logic [7:0] KEY_A     = 8'h04;
    localparam logic [7:0] KEY_S     = 8'h16;
    localparam logic [7:0] KEY_D     = 8'h07;
    localparam logic [7:0] KEY_SPACE = 8'h2C;
    localparam logic [7:0] KEY_ENTER = 8'h28;

    // Distance along one axis
    function automatic coord_t coord_dist(input coord_t a, input coord_t b);
        return (a > b) ? a - b : b - a;
    endfunction

endpackage

`default_nettype wire

// ==== include/boxhead_config.svh ====
//--------------------------------------------------------------------------
// Game constants for the arena core
// Field size, enemy count, ranges, damage and tick counts
//--------------------------------------------------------------------------
`ifndef BOXHEAD_CONFIG_SVH
`define BOXHEAD_CONFIG_SVH

`define BH_ENEMY_NUM        4
`define BH_FIELD_W          320
`define BH_FIELD_H          240
`define BH_COORD_W          9

`define BH_FULL_BLOOD       100
`define BH_ENEMY_DAMAGE     5     // Blood per strike
`define BH_STRIKE_COOLDOWN  16    // Ticks
`define BH_TOUCH_RANGE      6
`define BH_HIT_RANGE        8
`define BH_ATTACK_REACH     12
`define BH_ATTACK_TICKS     4
`define BH_RESPAWN_TICKS    32

// Corner spawn points, 8 pixels in
`define BH_SPAWN_X0         8
`define BH_SPAWN_Y0         8
`define BH_SPAWN_X1         311
`define BH_SPAWN_Y1         8
`define BH_SPAWN_X2         8
`define BH_SPAWN_Y2         231
`define BH_SPAWN_X3         311
`define BH_SPAWN_Y3         231

`endif
